/* design/hart_pkg.sv */
`default_nettype none

package hart_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5; // 32 architectural registers, x0 hardwired

  typedef logic [XLEN-1:0] xlen_t; // data word or byte address
  typedef logic [31:0] inst_t; // raw instruction word as fetched
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [2:0] alu_op_t;

  // alu operation codes carried from decode into execute
  localparam alu_op_t ALU_ADD = 3'd0; // also the address adder for lw and sw
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_PASS_B = 3'd5; // lui just forwards its immediate

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // the one system instruction that is legal here
  localparam inst_t INST_EBREAK = 32'h0010_0073;

  // funct3 values that are accepted, everything else traps
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010; // lw and sw share this code
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000; // sub is add with bit 30 set

  // lsb of each field inside the instruction word
  localparam int RD_LSB = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int FUNCT7_LSB = 25;

  // fetch only ever leaves FETCH_RUN through ebreak, and reset brings it back
  typedef enum logic [0:0] {
    FETCH_RUN,
    FETCH_HALTED
  } fetch_state_t;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter hart_pkg::xlen_t RESET_ADDR = '0
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire logic            i_stall, // decode is holding its instruction for a cycle
  input  wire logic            i_halt, // ebreak sits in decode right now
  input  wire hart_pkg::inst_t i_imem_rdata,
  output hart_pkg::xlen_t      o_imem_raddr,
  output logic                 o_valid,
  output hart_pkg::inst_t      o_inst,
  output hart_pkg::xlen_t      o_pc
);

  hart_pkg::fetch_state_t state;
  hart_pkg::xlen_t pc;
  logic advance;

  // imem answers in the same cycle, so the pc is the read address as is
  assign o_imem_raddr = pc;
  assign advance = (state == hart_pkg::FETCH_RUN) && !i_stall; // stall freezes pc and decode reg

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= hart_pkg::FETCH_RUN;
      pc <= RESET_ADDR;
      o_valid <= 1'b0; // nothing in decode until the first fetch lands
    end else if (advance) begin
      if (i_halt) begin
        // the word fetched alongside ebreak is dropped, and nothing follows it
        state <= hart_pkg::FETCH_HALTED;
        o_valid <= 1'b0;
      end else begin
        pc <= pc + hart_pkg::xlen_t'(4);
        o_valid <= 1'b1;
      end
    end
  end

  // instruction and its pc are captured one cycle after the address is shown
  always_ff @(posedge i_clk) begin
    if (advance) begin
      o_inst <= i_imem_rdata;
      o_pc <= pc;
    end
  end

endmodule

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire hart_pkg::reg_addr_t i_rs1_addr,
  input  wire hart_pkg::reg_addr_t i_rs2_addr,
  output hart_pkg::xlen_t          o_rs1_data,
  output hart_pkg::xlen_t          o_rs2_data,
  input  wire logic                i_wen,
  input  wire hart_pkg::reg_addr_t i_waddr,
  input  wire hart_pkg::xlen_t     i_wdata
);

  hart_pkg::xlen_t regs [1:31]; // x0 has no storage behind it

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata; // a write aimed at x0 is simply lost
    end
  end

  // the writeback value is bypassed to a read of the same register, so an
  // instruction in decode already sees what is retiring in this cycle
  always_comb begin
    if (i_rs1_addr == '0) o_rs1_data = '0;
    else if (i_wen && (i_waddr == i_rs1_addr)) o_rs1_data = i_wdata;
    else o_rs1_data = regs[i_rs1_addr];
  end

  always_comb begin
    if (i_rs2_addr == '0) o_rs2_data = '0;
    else if (i_wen && (i_waddr == i_rs2_addr)) o_rs2_data = i_wdata;
    else o_rs2_data = regs[i_rs2_addr];
  end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_valid,
  input  wire hart_pkg::inst_t     i_inst,
  input  wire hart_pkg::xlen_t     i_pc,
  output hart_pkg::reg_addr_t      o_rs1_addr,
  output hart_pkg::reg_addr_t      o_rs2_addr,
  input  wire hart_pkg::xlen_t     i_rs1_data,
  input  wire hart_pkg::xlen_t     i_rs2_data,
  input  wire hart_pkg::reg_addr_t i_x_rd, // destination of whatever sits in execute
  input  wire logic                i_x_wen, // already qualified with execute's valid
  output logic                     o_stall,
  output logic                     o_halt,
  output logic                     o_x_valid,
  output hart_pkg::inst_t          o_x_inst,
  output hart_pkg::xlen_t          o_x_pc,
  output hart_pkg::alu_op_t        o_x_alu_op,
  output hart_pkg::xlen_t          o_x_op_a,
  output hart_pkg::xlen_t          o_x_op_b,
  output hart_pkg::xlen_t          o_x_store_data,
  output logic                     o_x_is_load,
  output logic                     o_x_is_store,
  output hart_pkg::reg_addr_t      o_x_rd,
  output logic                     o_x_wen,
  output logic                     o_x_trap,
  output logic                     o_x_halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  hart_pkg::xlen_t imm_i;
  hart_pkg::xlen_t imm_s;
  hart_pkg::xlen_t imm_u;
  hart_pkg::alu_op_t f3_alu;
  logic f3_ok;
  hart_pkg::alu_op_t alu_op;
  hart_pkg::xlen_t op_b;
  logic legal;
  logic use_rs1;
  logic use_rs2;
  logic writes_rd;
  logic is_load;
  logic is_store;
  logic is_ebreak;
  logic rs1_hit;
  logic rs2_hit;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[hart_pkg::FUNCT3_LSB +: 3];
  assign funct7 = i_inst[hart_pkg::FUNCT7_LSB +: 7];
  assign o_rs1_addr = i_inst[hart_pkg::RS1_LSB +: hart_pkg::REG_ADDR_W];
  assign o_rs2_addr = i_inst[hart_pkg::RS2_LSB +: hart_pkg::REG_ADDR_W];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]}; // split around rd's slot
  assign imm_u = {i_inst[31:12], 12'b0};

  // register and immediate forms share the funct3 to alu mapping
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      hart_pkg::F3_ADD: f3_alu = hart_pkg::ALU_ADD;
      hart_pkg::F3_XOR: f3_alu = hart_pkg::ALU_XOR;
      hart_pkg::F3_OR: f3_alu = hart_pkg::ALU_OR;
      hart_pkg::F3_AND: f3_alu = hart_pkg::ALU_AND;
      default: begin
        f3_alu = hart_pkg::ALU_ADD;
        f3_ok = 1'b0; // slt, shifts and friends are not part of this subset
      end
    endcase
  end

  always_comb begin
    legal = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    writes_rd = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_ebreak = 1'b0;
    alu_op = hart_pkg::ALU_ADD;
    op_b = imm_i;
    case (opcode)
      hart_pkg::OPC_OP: begin
        {use_rs1, use_rs2, writes_rd} = 3'b111;
        op_b = i_rs2_data;
        alu_op = (funct7 == hart_pkg::FUNCT7_SUB) ? hart_pkg::ALU_SUB : f3_alu;
        legal = (funct7 == hart_pkg::FUNCT7_SUB) ? (funct3 == hart_pkg::F3_ADD)
                                                 : (f3_ok && (funct7 == '0));
      end
      hart_pkg::OPC_OP_IMM: begin
        {use_rs1, writes_rd} = 2'b11;
        alu_op = f3_alu;
        legal = f3_ok;
      end
      hart_pkg::OPC_LUI: begin
        writes_rd = 1'b1;
        op_b = imm_u;
        alu_op = hart_pkg::ALU_PASS_B;
        legal = 1'b1;
      end
      hart_pkg::OPC_LOAD: begin
        {use_rs1, writes_rd, is_load} = 3'b111;
        legal = (funct3 == hart_pkg::F3_WORD); // only lw survives
      end
      hart_pkg::OPC_STORE: begin
        {use_rs1, use_rs2, is_store} = 3'b111;
        op_b = imm_s;
        legal = (funct3 == hart_pkg::F3_WORD);
      end
      hart_pkg::OPC_SYSTEM: begin
        is_ebreak = (i_inst == hart_pkg::INST_EBREAK); // ecall and csr ops trap
        legal = is_ebreak;
      end
      default: legal = 1'b0;
    endcase
  end

  // the producer in execute has not reached the write-first register file yet
  assign rs1_hit = use_rs1 && (o_rs1_addr != '0) && (o_rs1_addr == i_x_rd);
  assign rs2_hit = use_rs2 && (o_rs2_addr != '0) && (o_rs2_addr == i_x_rd);
  assign o_stall = i_valid && legal && i_x_wen && (rs1_hit || rs2_hit);
  assign o_halt = i_valid && is_ebreak; // ebreak reads nothing, so never stalls

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_x_valid <= 1'b0;
      o_x_is_load <= 1'b0;
      o_x_is_store <= 1'b0;
      o_x_wen <= 1'b0;
      o_x_trap <= 1'b0;
      o_x_halt <= 1'b0;
    end else begin
      o_x_valid <= i_valid && !o_stall; // a stall leaves a bubble behind
      o_x_is_load <= is_load && legal;
      o_x_is_store <= is_store && legal;
      o_x_wen <= writes_rd && legal; // an illegal word writes nothing
      o_x_trap <= !legal;
      o_x_halt <= is_ebreak;
    end
  end

  always_ff @(posedge i_clk) begin
    o_x_inst <= i_inst;
    o_x_pc <= i_pc;
    o_x_alu_op <= alu_op;
    o_x_op_a <= i_rs1_data;
    o_x_op_b <= op_b;
    o_x_store_data <= i_rs2_data;
    o_x_rd <= i_inst[hart_pkg::RD_LSB +: hart_pkg::REG_ADDR_W];
  end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_x_valid,
  input  wire hart_pkg::inst_t     i_x_inst,
  input  wire hart_pkg::xlen_t     i_x_pc,
  input  wire hart_pkg::alu_op_t   i_x_alu_op,
  input  wire hart_pkg::xlen_t     i_x_op_a,
  input  wire hart_pkg::xlen_t     i_x_op_b,
  input  wire hart_pkg::xlen_t     i_x_store_data,
  input  wire logic                i_x_is_load,
  input  wire logic                i_x_is_store,
  input  wire hart_pkg::reg_addr_t i_x_rd,
  input  wire logic                i_x_wen,
  input  wire logic                i_x_trap,
  input  wire logic                i_x_halt,
  output hart_pkg::xlen_t          o_dmem_addr,
  output logic                     o_dmem_ren,
  output logic                     o_dmem_wen,
  output hart_pkg::xlen_t          o_dmem_wdata,
  input  wire hart_pkg::xlen_t     i_dmem_rdata,
  output hart_pkg::reg_addr_t      o_x_rd, // interlock feedback to decode
  output logic                     o_x_wen,
  output logic                     o_wb_wen,
  output hart_pkg::reg_addr_t      o_wb_rd,
  output hart_pkg::xlen_t          o_wb_data,
  output logic                     o_retire_valid,
  output logic                     o_retire_trap,
  output logic                     o_retire_halt,
  output hart_pkg::inst_t          o_retire_inst,
  output hart_pkg::xlen_t          o_retire_pc,
  output hart_pkg::reg_addr_t      o_retire_rd_waddr,
  output hart_pkg::xlen_t          o_retire_rd_wdata
);

  hart_pkg::xlen_t alu_res;
  hart_pkg::xlen_t result;
  logic wb_valid;
  logic wb_wen;
  logic wb_trap;
  logic wb_halt;
  hart_pkg::reg_addr_t wb_rd;
  hart_pkg::xlen_t wb_data;
  hart_pkg::inst_t wb_inst;
  hart_pkg::xlen_t wb_pc;

  always_comb begin
    case (i_x_alu_op)
      hart_pkg::ALU_ADD: alu_res = i_x_op_a + i_x_op_b;
      hart_pkg::ALU_SUB: alu_res = i_x_op_a - i_x_op_b;
      hart_pkg::ALU_AND: alu_res = i_x_op_a & i_x_op_b;
      hart_pkg::ALU_OR: alu_res = i_x_op_a | i_x_op_b;
      hart_pkg::ALU_XOR: alu_res = i_x_op_a ^ i_x_op_b;
      hart_pkg::ALU_PASS_B: alu_res = i_x_op_b;
      default: alu_res = '0;
    endcase
  end

  // lw and sw are word accesses only, the two low address bits never reach dmem
  assign o_dmem_addr = {alu_res[31:2], 2'b00};
  assign o_dmem_ren = i_x_valid && i_x_is_load; // decode never sets both flags
  assign o_dmem_wen = i_x_valid && i_x_is_store;
  assign o_dmem_wdata = i_x_store_data;
  assign result = i_x_is_load ? i_dmem_rdata : alu_res; // dmem reads within the cycle

  assign o_x_rd = i_x_rd;
  assign o_x_wen = i_x_valid && i_x_wen; // bubbles never cause a stall

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
      wb_wen <= 1'b0;
      wb_trap <= 1'b0;
      wb_halt <= 1'b0;
    end else begin
      wb_valid <= i_x_valid;
      wb_wen <= i_x_valid && i_x_wen && !i_x_trap;
      wb_trap <= i_x_valid && i_x_trap;
      wb_halt <= i_x_valid && i_x_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_rd <= (i_x_wen && !i_x_trap) ? i_x_rd : '0; // stores and traps report rd 0
    wb_data <= result;
    wb_inst <= i_x_inst;
    wb_pc <= i_x_pc;
  end

  // the same register drives the register file write and the retire report
  assign o_wb_wen = wb_wen;
  assign o_wb_rd = wb_rd;
  assign o_wb_data = wb_data;
  assign o_retire_valid = wb_valid;
  assign o_retire_trap = wb_trap;
  assign o_retire_halt = wb_halt;
  assign o_retire_inst = wb_inst;
  assign o_retire_pc = wb_pc;
  assign o_retire_rd_waddr = wb_rd;
  assign o_retire_rd_wdata = wb_data;

endmodule

`default_nettype wire

/* design/hart.sv */
`timescale 1ns/1ps
`default_nettype none

module hart #(
  parameter hart_pkg::xlen_t RESET_ADDR = '0 // any word-aligned start address
) (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  output hart_pkg::xlen_t      o_imem_raddr,
  input  wire hart_pkg::inst_t i_imem_rdata,
  output hart_pkg::xlen_t      o_dmem_addr,
  output logic                 o_dmem_ren,
  output logic                 o_dmem_wen,
  output hart_pkg::xlen_t      o_dmem_wdata,
  input  wire hart_pkg::xlen_t i_dmem_rdata,
  output logic                 o_retire_valid,
  output logic                 o_retire_trap,
  output logic                 o_retire_halt,
  output hart_pkg::inst_t      o_retire_inst,
  output hart_pkg::xlen_t      o_retire_pc,
  output hart_pkg::reg_addr_t  o_retire_rd_waddr,
  output hart_pkg::xlen_t      o_retire_rd_wdata
);

  logic d_valid; // fetch to decode
  hart_pkg::inst_t d_inst;
  hart_pkg::xlen_t d_pc;
  logic stall; // decode back to fetch
  logic halt;
  hart_pkg::reg_addr_t rs1_addr;
  hart_pkg::reg_addr_t rs2_addr;
  hart_pkg::xlen_t rs1_data;
  hart_pkg::xlen_t rs2_data;
  logic x_valid; // decode to execute
  hart_pkg::inst_t x_inst;
  hart_pkg::xlen_t x_pc;
  hart_pkg::alu_op_t x_alu_op;
  hart_pkg::xlen_t x_op_a;
  hart_pkg::xlen_t x_op_b;
  hart_pkg::xlen_t x_store_data;
  logic x_is_load;
  logic x_is_store;
  hart_pkg::reg_addr_t x_rd;
  logic x_wen;
  logic x_trap;
  logic x_halt;
  hart_pkg::reg_addr_t ex_rd; // execute's destination, seen by the interlock
  logic ex_wen;
  logic wb_wen;
  hart_pkg::reg_addr_t wb_rd;
  hart_pkg::xlen_t wb_data;

  fetch_stage #(.RESET_ADDR(RESET_ADDR)) fetch_i (
    .i_clk, .i_rst, .i_stall(stall), .i_halt(halt), .i_imem_rdata, .o_imem_raddr,
    .o_valid(d_valid), .o_inst(d_inst), .o_pc(d_pc)
  );

  decode_stage decode_i (
    .i_clk, .i_rst, .i_valid(d_valid), .i_inst(d_inst), .i_pc(d_pc),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .i_rs1_data(rs1_data),
    .i_rs2_data(rs2_data), .i_x_rd(ex_rd), .i_x_wen(ex_wen), .o_stall(stall),
    .o_halt(halt), .o_x_valid(x_valid), .o_x_inst(x_inst), .o_x_pc(x_pc),
    .o_x_alu_op(x_alu_op), .o_x_op_a(x_op_a), .o_x_op_b(x_op_b),
    .o_x_store_data(x_store_data), .o_x_is_load(x_is_load), .o_x_is_store(x_is_store),
    .o_x_rd(x_rd), .o_x_wen(x_wen), .o_x_trap(x_trap), .o_x_halt(x_halt)
  );

  register_file regfile_i (
    .i_clk, .i_rst, .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_wen(wb_wen), .i_waddr(wb_rd), .i_wdata(wb_data)
  );

  execute_stage execute_i (
    .i_clk, .i_rst, .i_x_valid(x_valid), .i_x_inst(x_inst), .i_x_pc(x_pc),
    .i_x_alu_op(x_alu_op), .i_x_op_a(x_op_a), .i_x_op_b(x_op_b),
    .i_x_store_data(x_store_data), .i_x_is_load(x_is_load), .i_x_is_store(x_is_store),
    .i_x_rd(x_rd), .i_x_wen(x_wen), .i_x_trap(x_trap), .i_x_halt(x_halt),
    .o_dmem_addr, .o_dmem_ren, .o_dmem_wen, .o_dmem_wdata, .i_dmem_rdata,
    .o_x_rd(ex_rd), .o_x_wen(ex_wen), .o_wb_wen(wb_wen), .o_wb_rd(wb_rd),
    .o_wb_data(wb_data), .o_retire_valid, .o_retire_trap, .o_retire_halt,
    .o_retire_inst, .o_retire_pc, .o_retire_rd_waddr, .o_retire_rd_wdata
  );

endmodule

`default_nettype wire

/* verification/hart_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module hart_properties (
  input wire logic            i_clk,
  input wire logic            i_rst,
  input wire logic            i_dmem_ren,
  input wire logic            i_dmem_wen,
  input wire hart_pkg::xlen_t i_dmem_addr,
  input wire logic            i_retire_valid,
  input wire logic            i_retire_halt
);

  logic halted; // ebreak has retired since the last reset
  int unsigned fail_count = 0;

  always_ff @(posedge i_clk) begin
    if (i_rst) halted <= 1'b0;
    else if (i_retire_valid && i_retire_halt) halted <= 1'b1;
  end

  // the first reset edge clears the outputs and they stay low while reset is held
  reset_quiet: assert property (@(posedge i_clk)
    i_rst |=> !i_retire_valid && !i_dmem_ren && !i_dmem_wen)
    else begin
      fail_count++;
      $error("retire or dmem enable active during reset");
    end

  ren_wen_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_ren && i_dmem_wen))
    else begin
      fail_count++;
      $error("dmem read and write enabled together");
    end

  addr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_dmem_ren || i_dmem_wen) |-> (i_dmem_addr[1:0] == 2'b00))
    else begin
      fail_count++;
      $error("dmem access at unaligned address %h", i_dmem_addr);
    end

  silent_after_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    halted |-> !i_retire_valid)
    else begin
      fail_count++;
      $error("instruction retired after ebreak");
    end

endmodule

bind hart hart_properties props_i (
  .i_clk(i_clk), .i_rst(i_rst), .i_dmem_ren(o_dmem_ren), .i_dmem_wen(o_dmem_wen),
  .i_dmem_addr(o_dmem_addr), .i_retire_valid(o_retire_valid), .i_retire_halt(o_retire_halt)
);

`default_nettype wire

/* verification/hart_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module hart_monitor #(
  parameter int NAME_LEN = 12
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_retire_valid,
  input  wire logic                  i_retire_trap,
  input  wire logic                  i_retire_halt,
  input  wire hart_pkg::inst_t       i_retire_inst,
  input  wire hart_pkg::xlen_t       i_retire_pc,
  input  wire hart_pkg::reg_addr_t   i_retire_rd_waddr,
  input  wire hart_pkg::xlen_t       i_retire_rd_wdata,
  input  wire logic [8*NAME_LEN-1:0] i_exp_name, // row selected by o_row_count
  input  wire hart_pkg::inst_t       i_exp_inst,
  input  wire hart_pkg::xlen_t       i_exp_pc,
  input  wire hart_pkg::reg_addr_t   i_exp_rd,
  input  wire hart_pkg::xlen_t       i_exp_data,
  input  wire logic                  i_exp_trap,
  input  wire logic                  i_exp_halt,
  input  wire logic [31:0]           i_num_rows,
  output logic [31:0]                o_row_count,
  output logic [31:0]                o_error_count
);

  logic mismatch;

  // write data only means something when a real register is written
  assign mismatch = (i_retire_pc !== i_exp_pc) || (i_retire_inst !== i_exp_inst) ||
                    (i_retire_rd_waddr !== i_exp_rd) || (i_retire_trap !== i_exp_trap) ||
                    (i_retire_halt !== i_exp_halt) ||
                    ((i_exp_rd != '0) && (i_retire_rd_wdata !== i_exp_data));

  // retire ports change on the rising edge, so the falling edge sees them settled
  always @(negedge i_clk) begin
    if (i_rst) begin
      o_row_count <= '0;
      o_error_count <= '0;
    end else if (i_retire_valid) begin
      if (o_row_count >= i_num_rows) begin
        $display("unexpected retirement of %h at pc %h after the program ended",
                 i_retire_inst, i_retire_pc);
        o_error_count <= o_error_count + 1;
      end else if (mismatch) begin
        // expected and actual halves go out on the same line
        $write("[FAIL] %s expected pc=%h inst=%h rd=%0d data=%h trap=%b halt=%b,",
               i_exp_name, i_exp_pc, i_exp_inst, i_exp_rd, i_exp_data, i_exp_trap,
               i_exp_halt);
        $display(" actual pc=%h inst=%h rd=%0d data=%h trap=%b halt=%b", i_retire_pc,
                 i_retire_inst, i_retire_rd_waddr, i_retire_rd_wdata, i_retire_trap,
                 i_retire_halt);
        o_error_count <= o_error_count + 1;
      end else begin
        $display("[PASS] %s pc=%h rd=%0d data=%h", i_exp_name, i_retire_pc,
                 i_retire_rd_waddr, i_retire_rd_wdata);
      end
      o_row_count <= o_row_count + 1; // one row consumed per retirement
    end
  end

endmodule

`default_nettype wire

/* verification/hart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hart_tb;

  localparam hart_pkg::xlen_t RESET_ADDR = 32'h0000_0040;
  localparam int MAX_ROWS = 32;
  localparam int NAME_LEN = 12; // characters kept per row name
  localparam int IMEM_WORDS = 32;
  localparam int DMEM_WORDS = 256;
  localparam int RETIRE_TIMEOUT = 20; // cycles per retirement, interlock bubbles included
  localparam int QUIET_CYCLES = 30; // window after ebreak in which nothing may retire
  localparam hart_pkg::inst_t NOP = 32'h0000_0013; // addi x0, x0, 0
  localparam hart_pkg::xlen_t DMEM_BASE = 32'h0000_0040;
  localparam hart_pkg::xlen_t STORE_ADDR = DMEM_BASE + 32'd8; // sw and lw both use 8(x14)

  // rv32i major opcodes, spelled out from the isa manual
  localparam logic [6:0] OPC_R = 7'b0110011;
  localparam logic [6:0] OPC_I = 7'b0010011;
  localparam logic [6:0] OPC_U = 7'b0110111;
  localparam logic [6:0] OPC_LW = 7'b0000011;
  localparam logic [6:0] OPC_SW = 7'b0100011;

  // expected results, each one built from the previous in two's complement
  localparam hart_pkg::xlen_t V_A = 32'd5;
  localparam hart_pkg::xlen_t V_B = -32'sd3;
  localparam hart_pkg::xlen_t V_SUM = V_A + V_B;
  localparam hart_pkg::xlen_t V_DIFF = V_SUM - V_A;
  localparam hart_pkg::xlen_t V_AND = V_DIFF & V_A;
  localparam hart_pkg::xlen_t V_OR = V_AND | V_B;
  localparam hart_pkg::xlen_t V_XOR = V_OR ^ V_A;
  localparam hart_pkg::xlen_t V_ANDI = V_XOR & 32'h0000_00F0;
  localparam hart_pkg::xlen_t V_ORI = V_ANDI | 32'h0000_0005;
  localparam hart_pkg::xlen_t V_XORI = V_ORI ^ 32'hFFFF_FFFF; // imm -1 sign-extends to all ones
  localparam hart_pkg::xlen_t V_LUI_A = {20'h12345, 12'h000};
  localparam hart_pkg::xlen_t V_LUI_B = {20'hABCDE, 12'h000};

  logic clk;
  logic rst;
  hart_pkg::xlen_t imem_raddr;
  hart_pkg::inst_t imem_rdata;
  hart_pkg::xlen_t imem_idx;
  hart_pkg::xlen_t dmem_addr;
  logic dmem_ren;
  logic dmem_wen;
  hart_pkg::xlen_t dmem_wdata;
  hart_pkg::xlen_t dmem_rdata;
  logic retire_valid;
  logic retire_trap;
  logic retire_halt;
  hart_pkg::inst_t retire_inst;
  hart_pkg::xlen_t retire_pc;
  hart_pkg::reg_addr_t retire_rd_waddr;
  hart_pkg::xlen_t retire_rd_wdata;

  logic [8*NAME_LEN-1:0] row_name [MAX_ROWS];
  hart_pkg::inst_t row_inst [MAX_ROWS];
  hart_pkg::reg_addr_t row_rd [MAX_ROWS];
  hart_pkg::xlen_t row_data [MAX_ROWS];
  logic row_trap [MAX_ROWS];
  logic row_halt [MAX_ROWS];
  int num_rows;
  logic [4:0] row_sel;
  logic [31:0] mon_rows;
  logic [31:0] mon_errors;
  hart_pkg::inst_t imem [IMEM_WORDS];
  hart_pkg::xlen_t dmem [DMEM_WORDS];

  always #50 clk = ~clk;

  function automatic hart_pkg::inst_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic hart_pkg::inst_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic hart_pkg::inst_t encode_sw(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_SW}; // offset is split around rs2
  endfunction

  function automatic hart_pkg::inst_t encode_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_U};
  endfunction

  // every address bit moves the pattern, so a wrong address never reads a plausible value
  function automatic hart_pkg::xlen_t fill_word(input hart_pkg::xlen_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'hA5A5_A5A5;
  endfunction

  task automatic add_row(input logic [8*NAME_LEN-1:0] name, input hart_pkg::inst_t inst,
      input hart_pkg::reg_addr_t rd, input hart_pkg::xlen_t data, input logic trap,
      input logic halt);
    row_name[num_rows] = name;
    row_inst[num_rows] = inst;
    row_rd[num_rows] = rd;
    row_data[num_rows] = data;
    row_trap[num_rows] = trap;
    row_halt[num_rows] = halt;
    num_rows++;
  endtask

  // rows retire in this order, each at RESET_ADDR plus four times its index
  task automatic build_program();
    add_row("addi_pos", encode_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_I), 5'd1, V_A, 1'b0, 1'b0);
    add_row("addi_neg", encode_i(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_I), 5'd2, V_B, 1'b0, 1'b0);
    add_row("add_dep", encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_R), 5'd3, V_SUM, 1'b0, 1'b0);
    add_row("sub_dep", encode_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, OPC_R), 5'd4, V_DIFF, 1'b0, 1'b0);
    add_row("and_dep", encode_r(7'h00, 5'd1, 5'd4, 3'b111, 5'd5, OPC_R), 5'd5, V_AND, 1'b0, 1'b0);
    add_row("or_dep", encode_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6, OPC_R), 5'd6, V_OR, 1'b0, 1'b0);
    add_row("xor_dep", encode_r(7'h00, 5'd1, 5'd6, 3'b100, 5'd7, OPC_R), 5'd7, V_XOR, 1'b0, 1'b0);
    add_row("andi", encode_i(12'h0F0, 5'd7, 3'b111, 5'd8, OPC_I), 5'd8, V_ANDI, 1'b0, 1'b0);
    add_row("ori", encode_i(12'h005, 5'd8, 3'b110, 5'd9, OPC_I), 5'd9, V_ORI, 1'b0, 1'b0);
    add_row("xori", encode_i(12'hFFF, 5'd9, 3'b100, 5'd10, OPC_I), 5'd10, V_XORI, 1'b0, 1'b0);
    add_row("x0_write", encode_i(12'd7, 5'd1, 3'b000, 5'd0, OPC_I), 5'd0, '0, 1'b0, 1'b0);
    add_row("x0_read", encode_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd11, OPC_R), 5'd11, V_A, 1'b0, 1'b0);
    add_row("lui_a", encode_lui(20'h12345, 5'd12), 5'd12, V_LUI_A, 1'b0, 1'b0);
    add_row("lui_b", encode_lui(20'hABCDE, 5'd13), 5'd13, V_LUI_B, 1'b0, 1'b0);
    add_row("addi_base", encode_i(DMEM_BASE[11:0], 5'd0, 3'b000, 5'd14, OPC_I), 5'd14, DMEM_BASE,
            1'b0, 1'b0);
    add_row("sw_word", encode_sw(12'd8, 5'd12, 5'd14), 5'd0, '0, 1'b0, 1'b0); // stores report rd 0
    add_row("lw_word", encode_i(12'd8, 5'd14, 3'b010, 5'd15, OPC_LW), 5'd15, V_LUI_A, 1'b0, 1'b0);
    add_row("add_load", encode_r(7'h00, 5'd13, 5'd15, 3'b000, 5'd16, OPC_R), 5'd16,
            V_LUI_A + V_LUI_B, 1'b0, 1'b0);
    add_row("slt_trap", encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd17, OPC_R), 5'd0, '0, 1'b1, 1'b0);
    add_row("ecall_trap", 32'h0000_0073, 5'd0, '0, 1'b1, 1'b0);
    add_row("after_trap", encode_i(12'd1, 5'd17, 3'b000, 5'd18, OPC_I), 5'd18, 32'd1, 1'b0, 1'b0);
    add_row("ebreak", 32'h0010_0073, 5'd0, '0, 1'b0, 1'b1);
  endtask

  // instruction memory answers within the cycle, outside the program it returns nops
  assign imem_idx = (imem_raddr - RESET_ADDR) >> 2;
  assign imem_rdata = (imem_idx < IMEM_WORDS) ? imem[imem_idx[4:0]] : NOP;

  // data memory reads combinationally and writes on the rising edge
  // without a read enable the data bus carries x, so a load that forgets ren returns garbage
  assign dmem_rdata = !dmem_ren ? 'x
                    : (dmem_addr < DMEM_WORDS * 4) ? dmem[dmem_addr[9:2]] : fill_word(dmem_addr);

  always @(posedge clk) begin
    if (dmem_wen && (dmem_addr < DMEM_WORDS * 4)) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  hart #(.RESET_ADDR(RESET_ADDR)) dut_i (
    .i_clk(clk), .i_rst(rst), .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
    .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
    .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata), .o_retire_valid(retire_valid),
    .o_retire_trap(retire_trap), .o_retire_halt(retire_halt), .o_retire_inst(retire_inst),
    .o_retire_pc(retire_pc), .o_retire_rd_waddr(retire_rd_waddr),
    .o_retire_rd_wdata(retire_rd_wdata)
  );

  assign row_sel = mon_rows[4:0]; // the monitor only looks at rows below num_rows

  hart_monitor #(.NAME_LEN(NAME_LEN)) mon_i (
    .i_clk(clk), .i_rst(rst), .i_retire_valid(retire_valid), .i_retire_trap(retire_trap),
    .i_retire_halt(retire_halt), .i_retire_inst(retire_inst), .i_retire_pc(retire_pc),
    .i_retire_rd_waddr(retire_rd_waddr), .i_retire_rd_wdata(retire_rd_wdata),
    .i_exp_name(row_name[row_sel]), .i_exp_inst(row_inst[row_sel]),
    .i_exp_pc(RESET_ADDR + (mon_rows << 2)), .i_exp_rd(row_rd[row_sel]),
    .i_exp_data(row_data[row_sel]), .i_exp_trap(row_trap[row_sel]),
    .i_exp_halt(row_halt[row_sel]), .i_num_rows(num_rows),
    .o_row_count(mon_rows), .o_error_count(mon_errors)
  );

  initial begin
    int waited;
    int mem_errors;
    int total_errors;
    logic timed_out;
    clk = 1'b0;
    rst = 1'b1; // driven before anything else so the first edge already sees reset
    num_rows = 0;
    mem_errors = 0;
    timed_out = 1'b0;
    build_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < num_rows) ? row_inst[i] : NOP;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(hart_pkg::xlen_t'(i * 4));
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // wait for each row in turn, the monitor bumps its count as each one retires
    for (int k = 0; (k < num_rows) && !timed_out; k++) begin
      waited = 0;
      while ((mon_rows <= k) && (waited < RETIRE_TIMEOUT)) begin
        @(negedge clk);
        waited++;
      end
      if (mon_rows <= k) begin
        $display("timeout: row %0d (%s) did not retire within %0d cycles", k, row_name[k],
                 RETIRE_TIMEOUT);
        timed_out = 1'b1;
      end
    end

    // after ebreak the hart stays silent, any late retirement is flagged by the monitor
    waited = 0;
    while (!timed_out && (waited < QUIET_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk); // the monitor's last update lands before the counts are read

    if (dmem[STORE_ADDR[9:2]] !== V_LUI_A) begin
      $display("[FAIL] dmem_word expected %h actual %h", V_LUI_A, dmem[STORE_ADDR[9:2]]);
      mem_errors++;
    end else begin
      $display("[PASS] dmem_word %h", dmem[STORE_ADDR[9:2]]);
    end

    total_errors = mon_errors + mem_errors + dut_i.props_i.fail_count;
    $display("rows retired %0d of %0d, errors %0d, assertion failures %0d, timeouts %0d",
             mon_rows, num_rows, total_errors, dut_i.props_i.fail_count, timed_out);
    if (timed_out || (total_errors != 0)) begin
      $display("TEST FAIL");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/hart_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/hart.sv
verification/hart_properties.sv
verification/hart_monitor.sv
verification/hart_tb.sv

/* Bender.yml */
package:
  name: rv32i_mini_hart

sources:
  # synthesizable hart, package first
  - files:
      - design/hart_pkg.sv
      - design/fetch_stage.sv
      - design/register_file.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/hart.sv
  # testbench, monitor and bound assertions
  - target: test
    files:
      - verification/hart_properties.sv
      - verification/hart_monitor.sv
      - verification/hart_tb.sv
